//--- hw/g729_params.svh
`ifndef G729_PARAMS_SVH
`define G729_PARAMS_SVH

//////////////////////////////////////////////////
// Word widths
//////////////////////////////////////////////////
`define G729_WORD_W 16
`define G729_LONG_W 32

//////////////////////////////////////////////////
// Saturation limits, signed literals
//////////////////////////////////////////////////
`define G729_MAX_16 16'sh7fff
`define G729_MIN_16 16'sh8000
`define G729_MAX_32 32'sh7fffffff
`define G729_MIN_32 32'sh80000000

`endif

//--- hw/g729_pkg.sv
`include "g729_params.svh"

package g729_pkg;

	//////////////////////////////////////////////////
	// Basic G.729 words
	//////////////////////////////////////////////////

	// Q15 fractional word
	typedef logic signed [`G729_WORD_W-1:0] word16_t;

	// Q31 long word
	typedef logic signed [`G729_LONG_W-1:0] word32_t;

	//////////////////////////////////////////////////
	// Double precision operand
	//////////////////////////////////////////////////

	// hi in the upper half, as L_Extract leaves it
	typedef struct packed {
		word16_t hi;
		word16_t lo;
	} dpf_pair_t;

	// Same bits, long view or hi/lo view
	typedef union packed {
		word32_t   full;
		dpf_pair_t half;
	} dpf_t;

endpackage

//--- hw/l_mult.sv
`timescale 1ns/1ps
`include "g729_params.svh"

// L_mult: fractional multiply, result doubled into Q31
module l_mult (
	input  g729_pkg::word16_t a,
	input  g729_pkg::word16_t b,
	output g729_pkg::word32_t p,
	output logic              ovf
);
	import g729_pkg::*;

	// Raw signed product, inputs sign extended by context
	word32_t prod;

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////

	assign prod = a * b;

	// Only -1 * -1 leaves the Q31 range after doubling
	assign ovf = (a == `G729_MIN_16) && (b == `G729_MIN_16);

	// Doubling drops the redundant sign bit
	always_comb begin
		if (ovf) begin
			p = `G729_MAX_32;
		end else begin
			p = prod <<< 1;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Doubled product keeps the sign of a * b, saturated or not
	always_comb begin
		assert final (a == '0 || b == '0 ||
				p[`G729_LONG_W-1] == (a[`G729_WORD_W-1] ^ b[`G729_WORD_W-1]))
			else $error("l_mult: %h * %h gave %h", a, b, p);
	end

endmodule

//--- hw/mult.sv
`timescale 1ns/1ps
`include "g729_params.svh"

// mult: fractional multiply, Q15 result truncated
module mult (
	input  g729_pkg::word16_t a,
	input  g729_pkg::word16_t b,
	output g729_pkg::word16_t p,
	output logic              ovf
);
	import g729_pkg::*;

	word32_t prod;
	// Product scaled back to Q15, still 32 bits wide
	word32_t shifted;

	assign prod    = a * b;
	assign shifted = prod >>> (`G729_WORD_W - 1);

	// Upper bits must all match the Q15 sign bit
	assign ovf = shifted[`G729_LONG_W-1:`G729_WORD_W-1] !=
		{(`G729_LONG_W - `G729_WORD_W + 1){shifted[`G729_WORD_W-1]}};

	// Saturate toward the sign of the true product
	always_comb begin
		if (!ovf) begin
			p = shifted[`G729_WORD_W-1:0];
		end else if (shifted[`G729_LONG_W-1]) begin
			p = `G729_MIN_16;
		end else begin
			p = `G729_MAX_16;
		end
	end

	// Like signs never give a negative full scale result
	always_comb begin
		assert final (!(a != '0 && b != '0 && a[`G729_WORD_W-1] == b[`G729_WORD_W-1])
				|| p != `G729_MIN_16)
			else $error("mult: %h * %h gave %h", a, b, p);
	end

endmodule

//--- hw/l_mac.sv
`timescale 1ns/1ps
`include "g729_params.svh"

// L_mac: acc + L_mult(a, b), both steps saturating
module l_mac (
	input  g729_pkg::word32_t acc,
	input  g729_pkg::word16_t a,
	input  g729_pkg::word16_t b,
	output g729_pkg::word32_t sum,
	output logic              ovf
);
	import g729_pkg::*;

	word32_t prod;
	word32_t prod_sat;
	word32_t raw;
	logic    mul_ovf;
	logic    add_ovf;
	// Exact sum, one guard bit
	logic [`G729_LONG_W:0] sum_wide;

	//////////////////////////////////////////////////
	// Multiply stage, same rule as L_mult
	//////////////////////////////////////////////////

	assign prod     = a * b;
	assign mul_ovf  = (a == `G729_MIN_16) && (b == `G729_MIN_16);
	assign prod_sat = mul_ovf ? `G729_MAX_32 : (prod <<< 1);

	//////////////////////////////////////////////////
	// Accumulate stage, L_add
	//////////////////////////////////////////////////

	// Wrapping sum
	assign raw = acc + prod_sat;

	// Overflow only when addends agree in sign and the sum does not
	assign add_ovf = (acc[`G729_LONG_W-1] == prod_sat[`G729_LONG_W-1]) &&
		(raw[`G729_LONG_W-1] != acc[`G729_LONG_W-1]);

	assign sum = add_ovf ? (acc[`G729_LONG_W-1] ? `G729_MIN_32 : `G729_MAX_32) : raw;
	assign ovf = mul_ovf | add_ovf;

	assign sum_wide = {acc[`G729_LONG_W-1], acc} + {prod_sat[`G729_LONG_W-1], prod_sat};

	// Saturated or not, sum has the sign of the exact sum
	always_comb begin
		assert final (sum[`G729_LONG_W-1] == sum_wide[`G729_LONG_W])
			else $error("l_mac: sign lost, acc %h sum %h", acc, sum);
		// Adder flags exactly the sums that leave 32 bits
		assert final (add_ovf == (sum_wide[`G729_LONG_W] != sum_wide[`G729_LONG_W-1]))
			else $error("l_mac: add_ovf %b for acc %h term %h", add_ovf, acc, prod_sat);
	end

endmodule

//--- hw/mpy_32.sv
`timescale 1ns/1ps
`include "g729_params.svh"

// Mpy_32 sequencer: L_mult(hi1,hi2), then two L_mac cross terms
module mpy_32 (
	input  logic              clock,
	input  logic              reset,
	input  logic              start,
	input  g729_pkg::dpf_t    var1,
	input  g729_pkg::dpf_t    var2,
	input  g729_pkg::word32_t l_mult_p,
	input  logic              l_mult_ovf,
	input  g729_pkg::word16_t mult_p,
	input  logic              mult_ovf,
	input  g729_pkg::word32_t l_mac_sum,
	input  logic              l_mac_ovf,
	output g729_pkg::word16_t l_mult_a,
	output g729_pkg::word16_t l_mult_b,
	output g729_pkg::word16_t mult_a,
	output g729_pkg::word16_t mult_b,
	output g729_pkg::word16_t l_mac_a,
	output g729_pkg::word16_t l_mac_b,
	output g729_pkg::word32_t l_mac_acc,
	output g729_pkg::word32_t result,
	output logic              overflow,
	output logic              done,
	output logic              busy
);
	import g729_pkg::*;

	// L_mac(x, 1) doubles the mult term, as in the C model
	localparam word16_t MAC_ONE = 16'sd1;

	typedef enum logic [2:0] {
		IDLE,
		L_MULT,
		MAC_HL,
		MAC_LH,
		DONE
	} state_t;

	state_t  state;
	state_t  state_next;
	// Partial product between operator steps
	word32_t product;
	// Sticky overflow of the running operation
	logic    ovf_acc;
	logic    step_ovf;

	//////////////////////////////////////////////////
	// State and status registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= IDLE;
			ovf_acc  <= 1'b0;
			result   <= '0;
			overflow <= 1'b0;
		end else begin
			state <= state_next;
			if (state == IDLE && start) begin
				ovf_acc <= 1'b0;
			end else begin
				ovf_acc <= ovf_acc | step_ovf;
			end
			// Last step, publish result and flag together
			if (state == MAC_LH) begin
				result   <= l_mac_sum;
				overflow <= ovf_acc | step_ovf;
			end
		end
	end

	// Each state overwrites the partial before it is read
	always_ff @(posedge clock) begin
		if (state == L_MULT) begin
			product <= l_mult_p;
		end else if (state == MAC_HL) begin
			product <= l_mac_sum;
		end
	end

	//////////////////////////////////////////////////
	// Next state and operator operands
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		step_ovf   = 1'b0;
		l_mult_a   = '0;
		l_mult_b   = '0;
		mult_a     = '0;
		mult_b     = '0;
		l_mac_a    = '0;
		l_mac_b    = '0;
		l_mac_acc  = '0;
		case (state)
			IDLE: begin
				if (start) begin
					state_next = L_MULT;
				end
			end
			// hi1 * hi2
			L_MULT: begin
				l_mult_a   = var1.half.hi;
				l_mult_b   = var2.half.hi;
				step_ovf   = l_mult_ovf;
				state_next = MAC_HL;
			end
			// + mult(hi1, lo2)
			MAC_HL: begin
				mult_a     = var1.half.hi;
				mult_b     = var2.half.lo;
				l_mac_a    = mult_p;
				l_mac_b    = MAC_ONE;
				l_mac_acc  = product;
				step_ovf   = mult_ovf | l_mac_ovf;
				state_next = MAC_LH;
			end
			// + mult(lo1, hi2)
			MAC_LH: begin
				mult_a     = var1.half.lo;
				mult_b     = var2.half.hi;
				l_mac_a    = mult_p;
				l_mac_b    = MAC_ONE;
				l_mac_acc  = product;
				step_ovf   = mult_ovf | l_mac_ovf;
				state_next = DONE;
			end
			DONE: begin
				state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	assign done = (state == DONE);
	assign busy = (state != IDLE);

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Accepted start completes four cycles later, in a single cycle pulse
	assert property (@(posedge clock) disable iff (reset)
		(state == IDLE && start) |=> !done ##1 !done ##1 !done ##1 done ##1 !done);

	// A start seen mid operation never republishes result or flag
	assert property (@(posedge clock) disable iff (reset)
		($changed(result) || $changed(overflow)) |-> done);

endmodule

//--- hw/mpy_32_top.sv
`timescale 1ns/1ps

// Mpy_32 controller with its three G.729 operators
module mpy_32_top (
	input  logic              clock,
	input  logic              reset,
	input  logic              start,
	input  g729_pkg::dpf_t    var1,
	input  g729_pkg::dpf_t    var2,
	output g729_pkg::word32_t result,
	output logic              overflow,
	output logic              done,
	output logic              busy
);
	import g729_pkg::*;

	// L_mult operator
	word16_t l_mult_a;
	word16_t l_mult_b;
	word32_t l_mult_p;
	logic    l_mult_ovf;

	// mult operator
	word16_t mult_a;
	word16_t mult_b;
	word16_t mult_p;
	logic    mult_ovf;

	// L_mac operator
	word16_t l_mac_a;
	word16_t l_mac_b;
	word32_t l_mac_acc;
	word32_t l_mac_sum;
	logic    l_mac_ovf;

	//////////////////////////////////////////////////
	// Controller
	//////////////////////////////////////////////////

	mpy_32 u_mpy_32 (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.var1       (var1),
		.var2       (var2),
		.l_mult_p   (l_mult_p),
		.l_mult_ovf (l_mult_ovf),
		.mult_p     (mult_p),
		.mult_ovf   (mult_ovf),
		.l_mac_sum  (l_mac_sum),
		.l_mac_ovf  (l_mac_ovf),
		.l_mult_a   (l_mult_a),
		.l_mult_b   (l_mult_b),
		.mult_a     (mult_a),
		.mult_b     (mult_b),
		.l_mac_a    (l_mac_a),
		.l_mac_b    (l_mac_b),
		.l_mac_acc  (l_mac_acc),
		.result     (result),
		.overflow   (overflow),
		.done       (done),
		.busy       (busy)
	);

	//////////////////////////////////////////////////
	// Operators, all combinational
	//////////////////////////////////////////////////

	l_mult u_l_mult (.a(l_mult_a), .b(l_mult_b), .p(l_mult_p), .ovf(l_mult_ovf));

	mult u_mult (.a(mult_a), .b(mult_b), .p(mult_p), .ovf(mult_ovf));

	l_mac u_l_mac (
		.acc (l_mac_acc),
		.a   (l_mac_a),
		.b   (l_mac_b),
		.sum (l_mac_sum),
		.ovf (l_mac_ovf)
	);

endmodule

//--- tb/tb_mpy_32.sv
`timescale 1ns/1ps

module tb_mpy_32;
	import g729_pkg::*;

	localparam int PERIOD       = 40;
	localparam int RESET_CYCLES = 5;
	localparam int TABLE_LEN    = 12;
	localparam int RANDOM_LEN   = 64;
	localparam int NUM_VECTORS  = TABLE_LEN + RANDOM_LEN;

	logic    clock;
	logic    reset;
	logic    start;
	dpf_t    var1;
	dpf_t    var2;
	word32_t result;
	logic    overflow;
	logic    done;
	logic    busy;

	// Table rows: poke bit, var1, var2
	logic [64:0] vectors [0:TABLE_LEN-1];
	logic [31:0] lfsr_state;
	// Result the DUT must hold between operations
	logic [31:0] held_result;
	int          error_count;
	int          check_count;

	mpy_32_top DUT (
		.clock    (clock),
		.reset    (reset),
		.start    (start),
		.var1     (var1),
		.var2     (var2),
		.result   (result),
		.overflow (overflow),
		.done     (done),
		.busy     (busy)
	);

	always #(PERIOD / 2) clock = ~clock;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic bit out_of_range(input longint v, input int bits);
		longint limit;
		limit = longint'(1) << (bits - 1);
		return (v >= limit) || (v < -limit);
	endfunction

	function automatic longint clamp(input longint v, input int bits);
		longint limit;
		limit = longint'(1) << (bits - 1);
		if (v >= limit) return limit - 1;
		if (v < -limit) return -limit;
		return v;
	endfunction

	// Mpy_32 from the G.729 definitions, overflow in bit 32
	function automatic logic [32:0] mpy_model(input logic [31:0] x, input logic [31:0] y);
		longint hi1;
		longint lo1;
		longint hi2;
		longint lo2;
		longint p;
		longint m;
		longint acc;
		bit     ov;
		hi1 = $signed(x[31:16]);
		lo1 = $signed(x[15:0]);
		hi2 = $signed(y[31:16]);
		lo2 = $signed(y[15:0]);
		// L_mult of the high halves
		p   = 2 * hi1 * hi2;
		ov  = out_of_range(p, 32);
		acc = clamp(p, 32);
		// Cross term hi1 * lo2, truncated Q15, then L_mac with 1
		p   = (hi1 * lo2) >>> 15;
		ov  = ov | out_of_range(p, 16);
		m   = clamp(p, 16);
		p   = acc + 2 * m;
		ov  = ov | out_of_range(p, 32);
		acc = clamp(p, 32);
		// Cross term lo1 * hi2
		p   = (lo1 * hi2) >>> 15;
		ov  = ov | out_of_range(p, 16);
		m   = clamp(p, 16);
		p   = acc + 2 * m;
		ov  = ov | out_of_range(p, 32);
		acc = clamp(p, 32);
		return {ov, acc[31:0]};
	endfunction

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1, Fibonacci form
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit of the word
	task automatic draw_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	// Called and left on a falling edge, so operations run back to back
	task automatic run_op(input logic [31:0] x, input logic [31:0] y, input bit poke);
		logic [32:0] expected;
		int          n;
		expected = mpy_model(x, y);
		var1  = x;
		var2  = y;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		n = 1;
		while (!done && n < 10) begin
			check("busy", 1, busy);
			// Previous result stays until this done
			check("result_held", held_result, result);
			// Extra start in the middle of the sequence
			start = poke && (n == 2);
			@(negedge clock);
			n++;
		end
		start = 1'b0;
		if (!done) begin
			error_count++;
			$display("done never rose for operands %h and %h", x, y);
		end else begin
			check("done_cycle", 4, n);
			check("busy", 1, busy);
			check("result", expected[31:0], result);
			check("overflow", expected[32], overflow);
		end
		held_result = expected[31:0];
		@(negedge clock);
		check("done_width", 0, done);
		check("busy_after", 0, busy);
		check("result_after", held_result, result);
	endtask

	task automatic load_table;
		vectors[0]  = {1'b0, 32'h00000000, 32'h00000000};
		vectors[1]  = {1'b0, 32'h80008000, 32'h80008000};
		vectors[2]  = {1'b0, 32'h80000000, 32'h80000000};
		vectors[3]  = {1'b0, 32'h7fffffff, 32'h7fffffff};
		vectors[4]  = {1'b0, 32'h7fff7fff, 32'h7fff7fff};
		vectors[5]  = {1'b0, 32'h7fff0000, 32'h80000000};
		vectors[6]  = {1'b0, 32'h80000000, 32'h7fff0000};
		vectors[7]  = {1'b1, 32'h40008000, 32'hc0004000};
		vectors[8]  = {1'b0, 32'h12348765, 32'h0fed9abc};
		vectors[9]  = {1'b1, 32'hffff8000, 32'h00018000};
		vectors[10] = {1'b0, 32'h20001234, 32'he000ffff};
		vectors[11] = {1'b1, 32'h80007fff, 32'h7fff8000};
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] x;
		logic [31:0] y;
		clock       = 1'b0;
		reset       = 1'b1;
		start       = 1'b0;
		var1        = '0;
		var2        = '0;
		lfsr_state  = 32'h658a;
		held_result = '0;
		error_count = 0;
		check_count = 0;
		load_table();
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		// Idle state straight out of reset
		check("done", 0, done);
		check("busy", 0, busy);
		check("overflow", 0, overflow);
		check("result", 0, result);
		for (int i = 0; i < TABLE_LEN; i++) begin
			run_op(vectors[i][63:32], vectors[i][31:0], vectors[i][64]);
		end
		for (int i = 0; i < RANDOM_LEN; i++) begin
			draw_word(x);
			draw_word(y);
			run_op(x, y, (i % 8) == 3);
		end
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Eight periods per vector and reset cycle
	initial begin
		#((NUM_VECTORS + RESET_CYCLES) * 8 * PERIOD);
		$display("Timeout: the run did not finish in time, %0d errors so far", error_count);
		$display("Errors found");
		$finish;
	end

endmodule

//--- src.f
+incdir+hw
hw/g729_pkg.sv
hw/l_mult.sv
hw/mult.sv
hw/l_mac.sv
hw/mpy_32.sv
hw/mpy_32_top.sv
tb/tb_mpy_32.sv

//--- Bender.yml
package:
  name: g729_mpy_32

sources:
  - include_dirs:
      - hw
    files:
      - hw/g729_pkg.sv
      - hw/l_mult.sv
      - hw/mult.sv
      - hw/l_mac.sv
      - hw/mpy_32.sv
      - hw/mpy_32_top.sv
  - target: simulation
    files:
      - tb/tb_mpy_32.sv
